/* common/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// first instruction address after reset
`define RESET_PC 32'h0000_0000

// number of instruction cache lines, power of two
`define ICACHE_LINES 16

// byte address width on both sides of the bus
`define ADDR_WIDTH 32

`endif

/* common/riscv_pkg.sv */
`include "cpu_cfg.svh"

package riscv_pkg;

    // byte address seen by the core
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // data word for loads and stores
    typedef logic [31:0] word_t;

    // one 32-bit instruction
    typedef logic [31:0] inst_t;

    // fetch sequence
    // BYTE0..BYTE3 name the next byte to put on the bus
    // PAUSE waits for the bus after the data port took it
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        BYTE0,
        BYTE1,
        BYTE2,
        BYTE3,
        PAUSE,
        FILL
    } fetch_state_e;

    // byte state for a given byte index
    function automatic fetch_state_e byte_state(input logic [1:0] idx);
        fetch_state_e st;
        case (idx)
            2'd0:    st = BYTE0;
            2'd1:    st = BYTE1;
            2'd2:    st = BYTE2;
            default: st = BYTE3;
        endcase
        return st;
    endfunction

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

    // one datum on the RAM bus
    typedef logic [7:0] byte_t;

    // byte lane inside a 32-bit word
    typedef logic [1:0] byte_idx_t;

    // access width of a load or store
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    // data port sequencer
    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_XFER,
        LSU_DONE
    } lsu_state_e;

    // who holds the byte bus this cycle
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_LSU
    } bus_owner_e;

    // lane of the last byte of an access
    function automatic byte_idx_t size_last_byte(input mem_size_e size);
        byte_idx_t last;
        case (size)
            SIZE_B:  last = 2'd0;
            SIZE_H:  last = 2'd1;
            default: last = 2'd3;
        endcase
        return last;
    endfunction

endpackage

/* fetch/inst_cache.sv */
`include "cpu_cfg.svh"

module inst_cache (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             query_i,
    input  riscv_pkg::addr_t query_addr_i,
    input  logic             fill_i,
    input  riscv_pkg::addr_t fill_addr_i,
    input  riscv_pkg::inst_t fill_inst_i,
    output logic             hit_o,
    output riscv_pkg::inst_t inst_o
);
    import riscv_pkg::*;

    localparam int LINES = `ICACHE_LINES;
    localparam int IDX_W = $clog2(LINES);
    localparam int ADR_W = $bits(addr_t);
    // word aligned, so the two low bits are not stored
    localparam int TAG_W = ADR_W - IDX_W - 2;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    inst_t            data_mem [LINES];
    tag_t             tag_mem  [LINES];
    logic [LINES-1:0] line_vld;

    idx_t q_idx;
    tag_t q_tag;
    logic q_vld;
    idx_t f_idx;

    assign f_idx = fill_addr_i[IDX_W+1:2];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            line_vld <= '0;
            q_vld    <= 1'b0;
        end else begin
            q_vld <= query_i;
            if (fill_i) begin
                line_vld[f_idx] <= 1'b1;
            end
        end
    end

    // lookup address held for the compare in the next cycle
    always_ff @(posedge clk) begin
        if (query_i) begin
            q_idx <= query_addr_i[IDX_W+1:2];
            q_tag <= query_addr_i[ADR_W-1:IDX_W+2];
        end
        if (fill_i) begin
            data_mem[f_idx] <= fill_inst_i;
            tag_mem[f_idx]  <= fill_addr_i[ADR_W-1:IDX_W+2];
        end
    end

    assign hit_o  = q_vld && line_vld[q_idx] && (tag_mem[q_idx] == q_tag);
    assign inst_o = data_mem[q_idx];

endmodule

/* fetch/if_fetch.sv */
`include "cpu_cfg.svh"

module if_fetch (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  riscv_pkg::addr_t redirect_pc_i,
    input  logic             fetch_gnt_i,
    input  mem_pkg::byte_t   mem_rdata_i,
    input  logic             cache_hit_i,
    input  riscv_pkg::inst_t cache_inst_i,
    output logic             fetch_req_o,
    output riscv_pkg::addr_t fetch_addr_o,
    output logic             cache_query_o,
    output riscv_pkg::addr_t query_addr_o,
    output logic             cache_fill_o,
    output riscv_pkg::addr_t fill_addr_o,
    output riscv_pkg::inst_t fill_inst_o,
    output logic             inst_valid_o,
    output riscv_pkg::inst_t inst_o,
    output riscv_pkg::addr_t inst_pc_o
);
    import riscv_pkg::*;
    import mem_pkg::*;

    fetch_state_e state;
    addr_t        pc;
    byte_idx_t    byte_idx;
    logic         rd_pend;
    inst_t        inst_buf;
    inst_t        inst_next;
    logic         start;
    logic         byte_phase;

    // new fetch only from IDLE, never while decode stalls
    assign start      = (state == IDLE) && !stall_i && !redirect_i;
    assign byte_phase = state inside {BYTE0, BYTE1, BYTE2, BYTE3, PAUSE};

    // returned byte enters at the top, little-endian after four shifts
    assign inst_next = {mem_rdata_i, inst_buf[31:8]};

    // ask for the bus already in LOOKUP on a miss so BYTE0 sees the grant
    assign fetch_req_o  = (byte_phase || (state == LOOKUP && !cache_hit_i)) && !redirect_i;
    assign fetch_addr_o = pc + addr_t'(byte_idx);

    assign cache_query_o = start;
    assign query_addr_o  = pc;

    // last byte arrives in FILL, written straight into the line
    assign cache_fill_o = (state == FILL) && !redirect_i;
    assign fill_addr_o  = pc;
    assign fill_inst_o  = inst_next;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state        <= IDLE;
            pc           <= `RESET_PC;
            byte_idx     <= '0;
            rd_pend      <= 1'b0;
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= 1'b0;
            rd_pend      <= 1'b0;
            if (redirect_i) begin
                // partial word is dropped, pending byte ignored
                state <= IDLE;
                pc    <= redirect_pc_i;
            end else begin
                case (state)
                    IDLE: begin
                        if (start) begin
                            state    <= LOOKUP;
                            byte_idx <= '0;
                        end
                    end
                    LOOKUP: begin
                        if (cache_hit_i) begin
                            inst_valid_o <= 1'b1;
                            pc           <= pc + addr_t'(4);
                            state        <= IDLE;
                        end else begin
                            state <= BYTE0;
                        end
                    end
                    BYTE0, BYTE1, BYTE2, BYTE3, PAUSE: begin
                        if (fetch_gnt_i) begin
                            // byte issued now, captured next cycle
                            rd_pend  <= 1'b1;
                            byte_idx <= byte_idx + 2'd1;
                            state    <= (byte_idx == 2'd3) ? FILL
                                                           : byte_state(byte_idx + 2'd1);
                        end else begin
                            // byte_idx keeps the resume point
                            state <= PAUSE;
                        end
                    end
                    FILL: begin
                        inst_valid_o <= 1'b1;
                        pc           <= pc + addr_t'(4);
                        state        <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // assembly buffer and delivered instruction
    always_ff @(posedge clk) begin
        if (rd_pend) begin
            inst_buf <= inst_next;
        end
        if (state == LOOKUP) begin
            inst_o    <= cache_inst_i;
            inst_pc_o <= pc;
        end else if (state == FILL) begin
            inst_o    <= inst_next;
            inst_pc_o <= pc;
        end
    end

    // a redirect cancels whatever was about to be delivered
    a_redirect_kills_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i) redirect_i |=> !inst_valid_o
    ) else $error("inst_valid_o after redirect_i");

    a_idle_no_req: assert property (
        @(posedge clk) disable iff (!arst_n_i) (state == IDLE) |-> !fetch_req_o
    ) else $error("fetch_req_o high in IDLE");

endmodule

/* rtl/lsu_port.sv */
module lsu_port (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               lsu_req_i,
    input  logic               lsu_we_i,
    input  mem_pkg::mem_size_e lsu_size_i,
    input  riscv_pkg::addr_t   lsu_addr_i,
    input  riscv_pkg::word_t   lsu_wdata_i,
    input  logic               lsu_gnt_i,
    input  mem_pkg::byte_t     mem_rdata_i,
    output logic               lsu_bus_req_o,
    output riscv_pkg::addr_t   lsu_bus_addr_o,
    output logic               lsu_bus_we_o,
    output mem_pkg::byte_t     lsu_bus_wdata_o,
    output logic               lsu_done_o,
    output riscv_pkg::word_t   lsu_rdata_o
);
    import riscv_pkg::*;
    import mem_pkg::*;

    lsu_state_e state;
    addr_t      base_addr;
    word_t      wdata_q;
    word_t      rdata_buf;
    word_t      rdata_merged;
    logic       we_q;
    byte_idx_t  idx;
    byte_idx_t  last_idx;
    byte_idx_t  cap_idx;
    logic       rd_pend;
    logic       issue;
    logic       accept;

    assign accept = (state == LSU_IDLE) && lsu_req_i;
    assign issue  = (state == LSU_XFER) && lsu_gnt_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= LSU_IDLE;
            we_q     <= 1'b0;
            idx      <= '0;
            last_idx <= '0;
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= issue && !we_q;
            case (state)
                LSU_IDLE: begin
                    if (lsu_req_i) begin
                        state    <= LSU_XFER;
                        we_q     <= lsu_we_i;
                        idx      <= '0;
                        last_idx <= size_last_byte(lsu_size_i);
                    end
                end
                LSU_XFER: begin
                    // one byte per granted cycle, lowest lane first
                    if (lsu_gnt_i) begin
                        idx <= idx + 2'd1;
                        if (idx == last_idx) begin
                            state <= LSU_DONE;
                        end
                    end
                end
                LSU_DONE: state <= LSU_IDLE;
                default:  state <= LSU_IDLE;
            endcase
        end
    end

    // operands latched once, read word starts at zero
    always_ff @(posedge clk) begin
        if (accept) begin
            base_addr <= lsu_addr_i;
            wdata_q   <= lsu_wdata_i;
            rdata_buf <= '0;
        end else if (rd_pend) begin
            rdata_buf <= rdata_merged;
        end
        if (issue) begin
            cap_idx <= idx;
        end
    end

    // byte of the previous read cycle lands in its own lane
    always_comb begin
        rdata_merged = rdata_buf;
        if (rd_pend) begin
            rdata_merged[{cap_idx, 3'b000} +: 8] = mem_rdata_i;
        end
    end

    assign lsu_bus_req_o   = accept || (state == LSU_XFER);
    assign lsu_bus_addr_o  = base_addr + addr_t'(idx);
    assign lsu_bus_we_o    = we_q;
    assign lsu_bus_wdata_o = wdata_q[{idx, 3'b000} +: 8];
    // last read byte is merged in the done cycle itself
    assign lsu_done_o      = (state == LSU_DONE);
    assign lsu_rdata_o     = rdata_merged;

    a_req_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n_i) lsu_req_i |-> (state == LSU_IDLE)
    ) else $error("lsu_req_i while an access is in progress");

endmodule

/* rtl/mem_arbiter.sv */
module mem_arbiter (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             fetch_req_i,
    input  riscv_pkg::addr_t fetch_addr_i,
    input  logic             lsu_req_i,
    input  riscv_pkg::addr_t lsu_addr_i,
    input  logic             lsu_we_i,
    input  mem_pkg::byte_t   lsu_wdata_i,
    output logic             fetch_gnt_o,
    output logic             lsu_gnt_o,
    output riscv_pkg::addr_t mem_addr_o,
    output logic             mem_re_o,
    output logic             mem_we_o,
    output mem_pkg::byte_t   mem_wdata_o
);
    import mem_pkg::*;

    bus_owner_e owner;
    bus_owner_e owner_next;

    // data port first, it also keeps the bus while it asks
    always_comb begin
        if (lsu_req_i) begin
            owner_next = OWN_LSU;
        end else if (fetch_req_i) begin
            owner_next = OWN_FETCH;
        end else begin
            owner_next = OWN_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner <= OWN_NONE;
        end else begin
            owner <= owner_next;
        end
    end

    assign fetch_gnt_o = (owner == OWN_FETCH);
    assign lsu_gnt_o   = (owner == OWN_LSU);

    // pins follow the owner, a cycle only when it still requests
    assign mem_addr_o  = lsu_gnt_o ? lsu_addr_i : fetch_addr_i;
    assign mem_re_o    = (fetch_gnt_o && fetch_req_i) || (lsu_gnt_o && lsu_req_i && !lsu_we_i);
    assign mem_we_o    = lsu_gnt_o && lsu_req_i && lsu_we_i;
    assign mem_wdata_o = lsu_wdata_i;

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(fetch_gnt_o && lsu_gnt_o)
    ) else $error("fetch and data grants overlap");

endmodule

/* rtl/if_mem_top.sv */
module if_mem_top (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               stall_i,
    input  logic               redirect_i,
    input  riscv_pkg::addr_t   redirect_pc_i,
    output logic               inst_valid_o,
    output riscv_pkg::inst_t   inst_o,
    output riscv_pkg::addr_t   inst_pc_o,
    input  logic               lsu_req_i,
    input  logic               lsu_we_i,
    input  mem_pkg::mem_size_e lsu_size_i,
    input  riscv_pkg::addr_t   lsu_addr_i,
    input  riscv_pkg::word_t   lsu_wdata_i,
    output logic               lsu_done_o,
    output riscv_pkg::word_t   lsu_rdata_o,
    output riscv_pkg::addr_t   mem_addr_o,
    output logic               mem_re_o,
    output logic               mem_we_o,
    output mem_pkg::byte_t     mem_wdata_o,
    input  mem_pkg::byte_t     mem_rdata_i
);
    import riscv_pkg::*;
    import mem_pkg::*;

    // fetch side
    logic  fetch_req;
    logic  fetch_gnt;
    addr_t fetch_addr;
    logic  cache_query;
    addr_t query_addr;
    logic  cache_hit;
    inst_t cache_inst;
    logic  cache_fill;
    addr_t fill_addr;
    inst_t fill_inst;

    // data port side
    logic  lsu_bus_req;
    logic  lsu_gnt;
    addr_t lsu_bus_addr;
    logic  lsu_bus_we;
    byte_t lsu_bus_wdata;

    if_fetch u_fetch (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_gnt_i   (fetch_gnt),
        .mem_rdata_i   (mem_rdata_i),
        .cache_hit_i   (cache_hit),
        .cache_inst_i  (cache_inst),
        .fetch_req_o   (fetch_req),
        .fetch_addr_o  (fetch_addr),
        .cache_query_o (cache_query),
        .query_addr_o  (query_addr),
        .cache_fill_o  (cache_fill),
        .fill_addr_o   (fill_addr),
        .fill_inst_o   (fill_inst),
        .inst_valid_o  (inst_valid_o),
        .inst_o        (inst_o),
        .inst_pc_o     (inst_pc_o)
    );

    inst_cache u_icache (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .query_i      (cache_query),
        .query_addr_i (query_addr),
        .fill_i       (cache_fill),
        .fill_addr_i  (fill_addr),
        .fill_inst_i  (fill_inst),
        .hit_o        (cache_hit),
        .inst_o       (cache_inst)
    );

    // read data goes to both peers, each knows when it is its own
    lsu_port u_lsu (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .lsu_req_i       (lsu_req_i),
        .lsu_we_i        (lsu_we_i),
        .lsu_size_i      (lsu_size_i),
        .lsu_addr_i      (lsu_addr_i),
        .lsu_wdata_i     (lsu_wdata_i),
        .lsu_gnt_i       (lsu_gnt),
        .mem_rdata_i     (mem_rdata_i),
        .lsu_bus_req_o   (lsu_bus_req),
        .lsu_bus_addr_o  (lsu_bus_addr),
        .lsu_bus_we_o    (lsu_bus_we),
        .lsu_bus_wdata_o (lsu_bus_wdata),
        .lsu_done_o      (lsu_done_o),
        .lsu_rdata_o     (lsu_rdata_o)
    );

    mem_arbiter u_arb (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fetch_req_i  (fetch_req),
        .fetch_addr_i (fetch_addr),
        .lsu_req_i    (lsu_bus_req),
        .lsu_addr_i   (lsu_bus_addr),
        .lsu_we_i     (lsu_bus_we),
        .lsu_wdata_i  (lsu_bus_wdata),
        .fetch_gnt_o  (fetch_gnt),
        .lsu_gnt_o    (lsu_gnt),
        .mem_addr_o   (mem_addr_o),
        .mem_re_o     (mem_re_o),
        .mem_we_o     (mem_we_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule

/* tests/tb_if_mem_top.sv */
`include "cpu_cfg.svh"

module tb_if_mem_top;
    timeunit 1ns;
    timeprecision 1ps;

    import riscv_pkg::*;
    import mem_pkg::*;

    localparam int RAM_BYTES  = 4096;
    localparam int NUM_TESTS  = 6;
    localparam int CLK_PERIOD = 20;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      stall_i;
    logic      redirect_i;
    addr_t     redirect_pc_i;
    logic      inst_valid_o;
    inst_t     inst_o;
    addr_t     inst_pc_o;
    logic      lsu_req_i;
    logic      lsu_we_i;
    mem_size_e lsu_size_i;
    addr_t     lsu_addr_i;
    word_t     lsu_wdata_i;
    logic      lsu_done_o;
    word_t     lsu_rdata_o;
    addr_t     mem_addr_o;
    logic      mem_re_o;
    logic      mem_we_o;
    byte_t     mem_wdata_o;
    byte_t     mem_rdata_i;

    // RAM model and its shadow copy
    byte_t ram     [RAM_BYTES];
    byte_t ref_mem [RAM_BYTES];
    byte_t rd_byte;

    // expected values
    addr_t exp_pc;
    addr_t last_pc;
    inst_t exp_inst;
    word_t exp_load;
    logic  ld_store;
    logic  hit_window;
    logic  stall_quiet;

    int     fail_cnt     = 0;
    int     fails_before = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    integer seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    if_mem_top dut (.*);

    // little-endian word from the shadow bytes
    function automatic word_t ref_word(input addr_t a);
        word_t w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_mem[a[11:0] + 12'(i)];
        end
        return w;
    endfunction

    always_comb exp_inst = ref_word(exp_pc);

    // next pc: reset pc, then +4 per delivery, redirect target wins
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exp_pc  <= `RESET_PC;
            last_pc <= `RESET_PC;
        end else if (redirect_i) begin
            exp_pc <= redirect_pc_i;
            if (inst_valid_o) begin
                last_pc <= exp_pc;
            end
        end else if (inst_valid_o) begin
            exp_pc  <= exp_pc + 32'd4;
            last_pc <= exp_pc;
        end
    end

    // byte RAM, same seeded sequence as the shadow
    initial begin : ram_model
        integer      ram_seed;
        logic [31:0] rnd;
        mem_rdata_i = '0;
        rd_byte     = '0;
        ram_seed    = 68;
        for (int i = 0; i < RAM_BYTES; i++) begin
            rnd    = $random(ram_seed);
            ram[i] = rnd[7:0];
        end
        forever begin
            @(posedge clk);
            if (mem_we_o) begin
                ram[mem_addr_o[11:0]] = mem_wdata_o;
            end
            if (mem_re_o) begin
                rd_byte = ram[mem_addr_o[11:0]];
            end
            // byte shows up mid-cycle, sampled at the next edge
            @(negedge clk);
            mem_rdata_i = rd_byte;
        end
    end

    a_reset_quiet: assert property (
        @(posedge clk) !arst_n_i |-> !inst_valid_o && !lsu_done_o && !mem_re_o && !mem_we_o
    ) else begin
        fail_cnt++;
        $display("valid, done or bus strobe active during reset");
    end

    a_inst_pc: assert property (
        @(posedge clk) disable iff (!arst_n_i) inst_valid_o |-> inst_pc_o == exp_pc
    ) else begin
        fail_cnt++;
        $display("[FAIL] inst_pc_o expected %08h got %08h", $sampled(exp_pc),
                 $sampled(inst_pc_o));
    end

    a_inst_data: assert property (
        @(posedge clk) disable iff (!arst_n_i) inst_valid_o |-> inst_o == exp_inst
    ) else begin
        fail_cnt++;
        $display("[FAIL] inst_o expected %08h got %08h", $sampled(exp_inst), $sampled(inst_o));
    end

    // a hit must not touch the bus
    a_hit_no_bus: assert property (
        @(posedge clk) disable iff (!arst_n_i) hit_window |-> !mem_re_o
    ) else begin
        fail_cnt++;
        $display("memory read seen while the instruction should come from the cache");
    end

    a_grant_excl: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(dut.fetch_gnt && dut.lsu_gnt)
    ) else begin
        fail_cnt++;
        $display("fetch and data grants high in the same cycle");
    end

    a_load_data: assert property (
        @(posedge clk) disable iff (!arst_n_i) lsu_done_o && !ld_store |-> lsu_rdata_o == exp_load
    ) else begin
        fail_cnt++;
        $display("[FAIL] lsu_rdata_o expected %08h got %08h", $sampled(exp_load),
                 $sampled(lsu_rdata_o));
    end

    a_stall_quiet: assert property (
        @(posedge clk) disable iff (!arst_n_i) stall_quiet |-> !inst_valid_o
    ) else begin
        fail_cnt++;
        $display("instruction delivered while decode is stalled");
    end

    task automatic wait_delivery();
        @(negedge clk);
        while (!inst_valid_o) begin
            @(negedge clk);
        end
    endtask

    task automatic redirect_to(input addr_t target, input logic expect_hit);
        @(negedge clk);
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        hit_window    = expect_hit;
        @(negedge clk);
        redirect_i = 1'b0;
    endtask

    // one load or store, shadow updated before the access starts
    task automatic data_access(input logic we, input mem_size_e size, input addr_t addr,
                               input word_t wdata);
        int    nbytes;
        word_t expect_word;
        @(negedge clk);
        case (size)
            SIZE_B:  nbytes = 1;
            SIZE_H:  nbytes = 2;
            default: nbytes = 4;
        endcase
        expect_word = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (we) begin
                ref_mem[addr[11:0] + 12'(i)] = wdata[8*i +: 8];
            end else begin
                expect_word[8*i +: 8] = ref_mem[addr[11:0] + 12'(i)];
            end
        end
        ld_store    = we;
        exp_load    = expect_word;
        lsu_req_i   = 1'b1;
        lsu_we_i    = we;
        lsu_size_i  = size;
        lsu_addr_i  = addr;
        lsu_wdata_i = wdata;
        @(negedge clk);
        lsu_req_i = 1'b0;
        while (!lsu_done_o) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        // let the last checks of the test sample first
        @(negedge clk);
        if (fail_cnt == fails_before) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, fail_cnt - fails_before);
        end
        fails_before = fail_cnt;
    endtask

    initial begin : stimulus
        logic [31:0] rnd;
        logic [31:0] wdata;
        addr_t       target;
        mem_size_e   size;
        seed = 68;
        for (int i = 0; i < RAM_BYTES; i++) begin
            rnd        = $random(seed);
            ref_mem[i] = rnd[7:0];
        end
        arst_n_i      = 1'b0;
        stall_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        lsu_req_i     = 1'b0;
        lsu_we_i      = 1'b0;
        lsu_size_i    = SIZE_B;
        lsu_addr_i    = '0;
        lsu_wdata_i   = '0;
        ld_store      = 1'b1;
        exp_load      = '0;
        hit_window    = 1'b0;
        stall_quiet   = 1'b0;
        repeat (16) @(negedge clk);
        arst_n_i = 1'b1;

        wait_delivery();
        finish_test(1, "reset and first fetch");

        repeat (12) wait_delivery();
        finish_test(2, "sequential fetch");

        // fetch stays below 0x800, data accesses above
        rnd    = $random(seed);
        target = {23'b0, rnd[8:2], 2'b00};
        redirect_to(target, 1'b0);
        repeat (4) wait_delivery();
        finish_test(3, "redirect");

        // last delivered pc is still in its line
        redirect_to(last_pc, 1'b1);
        wait_delivery();
        hit_window = 1'b0;
        finish_test(4, "cache hit");

        for (int k = 0; k < 24; k++) begin
            rnd   = $random(seed);
            wdata = $random(seed);
            case (rnd[16:15])
                2'd0:    size = SIZE_B;
                2'd1:    size = SIZE_H;
                default: size = SIZE_W;
            endcase
            repeat (rnd[14:12]) @(negedge clk);
            data_access(rnd[17], size, 32'h0000_0800 + {26'b0, rnd[10:5]}, wdata);
        end
        wait_delivery();
        finish_test(5, "data port under contention");

        @(negedge clk);
        stall_i = 1'b1;
        // fetch in flight finishes first
        while (!(dut.u_fetch.state == IDLE && !inst_valid_o)) begin
            @(negedge clk);
        end
        stall_quiet = 1'b1;
        repeat (20) @(negedge clk);
        stall_quiet = 1'b0;
        stall_i     = 1'b0;
        wait_delivery();
        finish_test(6, "stall");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d ns", NUM_TESTS * 400 * CLK_PERIOD);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* if_mem_top.f */
+incdir+common
common/riscv_pkg.sv
common/mem_pkg.sv
fetch/inst_cache.sv
fetch/if_fetch.sv
rtl/lsu_port.sv
rtl/mem_arbiter.sv
rtl/if_mem_top.sv
tests/tb_if_mem_top.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f if_mem_top.f --top-module tb_if_mem_top -o tb_if_mem_top

./obj_dir/tb_if_mem_top > sim.log 2>&1 || {
    cat sim.log
    echo "simulation exited with an error"
    exit 1
}
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
